//--- dv/wb_subsys_chk.sv
`timescale 1ns/100ps

`include "wb_defs.svh"

module wb_subsys_chk import wb_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       ms_valid,
    input word_t      ms_pc,
    input logic       ms_csr_we,
    input csr_num_t   ms_csr_num,
    input word_t      ms_csr_wmask,
    input word_t      ms_rkd_value,
    input logic       ms_ex,
    input logic       ms_ertn,
    input logic       ms_refetch,
    input logic       flush,
    input word_t      flush_pc,
    input logic [3:0] debug_wb_rf_we
);

    int unsigned fail_count = 0;

    logic     sh_valid;
    logic     sh_ex;
    logic     sh_ertn;
    logic     sh_refetch;
    logic     sh_flush;
    logic     sh_csr_we;
    csr_num_t sh_csr_num;
    word_t    sh_csr_wmask;
    word_t    sh_wvalue;
    word_t    sh_pc;
    word_t    sh_era;
    word_t    sh_eentry;
    word_t    target;

    // shadow of the instruction in writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            sh_valid  <= 1'b0;
            sh_era    <= '0;
            sh_eentry <= `EENTRY_RESET;
        end else begin
            sh_valid <= ms_valid & ~sh_flush;
            if (sh_valid && sh_ex) begin
                sh_era <= sh_pc;
            end else if (sh_valid && sh_csr_we && !sh_ertn) begin
                // csr writes to the flush targets
                if (sh_csr_num == `CSR_ERA) begin
                    sh_era <= (sh_era & ~sh_csr_wmask) | (sh_wvalue & sh_csr_wmask);
                end
                if (sh_csr_num == `CSR_EENTRY) begin
                    sh_eentry <= (sh_eentry & ~(sh_csr_wmask & 32'hffff_ffc0))
                                 | (sh_wvalue & sh_csr_wmask & 32'hffff_ffc0);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid) begin
            sh_pc        <= ms_pc;
            sh_ex        <= ms_ex;
            sh_ertn      <= ms_ertn;
            sh_refetch   <= ms_refetch;
            sh_csr_we    <= ms_csr_we;
            sh_csr_num   <= ms_csr_num;
            sh_csr_wmask <= ms_csr_wmask;
            sh_wvalue    <= ms_rkd_value;
        end
    end

    assign sh_flush = sh_valid & (sh_ex | sh_ertn | sh_refetch);
    assign target   = sh_ex ? sh_eentry : (sh_ertn ? sh_era : sh_pc + 32'd4);

    ex_no_commit: assert property (@(posedge clk) disable iff (reset)
        (sh_valid && sh_ex) |-> (debug_wb_rf_we == 4'h0))
        else begin
            $error("register commit while an exception is in writeback");
            fail_count++;
        end

    flush_when_due: assert property (@(posedge clk) disable iff (reset)
        flush == sh_flush)
        else begin
            $error("flush does not match the instruction in writeback");
            fail_count++;
        end

    flush_target: assert property (@(posedge clk) disable iff (reset)
        flush |-> (flush_pc == target))
        else begin
            $error("flush_pc is not the expected target");
            fail_count++;
        end

    // first cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!flush && (debug_wb_rf_we == 4'h0)))
        else begin
            $error("flush or commit right after reset");
            fail_count++;
        end

endmodule

//--- dv/wb_subsys_tb.sv
`timescale 1ns/100ps

`include "wb_defs.svh"

module wb_subsys_tb import wb_pkg::*; ();

    logic       clk, reset;
    logic       ms_valid, ms_gr_we, ms_csr_re, ms_csr_we, ms_ex, ms_ertn, ms_refetch;
    word_t      ms_pc, ms_result, ms_rkd_value, ms_csr_wmask, ms_badv;
    reg_addr_t  ms_dest, raddr1, raddr2, debug_wb_rf_wnum;
    csr_num_t   ms_csr_num;
    ecode_t     ms_ecode;
    esubcode_t  ms_esubcode;
    logic       flush;
    logic [3:0] debug_wb_rf_we;
    word_t      flush_pc, debug_wb_pc, debug_wb_rf_wdata, rdata1, rdata2;

    word_t       rng, cur_pc, exp_crmd, exp_prmd, exp_era, exp_save0;
    word_t       exp_regs [32];
    logic [31:0] written;
    int          test_errs, tests_run, tests_failed;

    wb_subsys u_wb_subsys (.*);

    bind wb_subsys wb_subsys_chk u_chk (
        .clk            (clk),
        .reset          (reset),
        .ms_valid       (ms_valid),
        .ms_pc          (ms_pc),
        .ms_csr_we      (ms_csr_we),
        .ms_csr_num     (ms_csr_num),
        .ms_csr_wmask   (ms_csr_wmask),
        .ms_rkd_value   (ms_rkd_value),
        .ms_ex          (ms_ex),
        .ms_ertn        (ms_ertn),
        .ms_refetch     (ms_refetch),
        .flush          (flush),
        .flush_pc       (flush_pc),
        .debug_wb_rf_we (debug_wb_rf_we)
    );

    always #10 clk = ~clk;

    function automatic word_t xorshift(input word_t s);
        word_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check_val(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("FAILED %0t %s expected %h got %h", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end else begin
            $display("test %s: ok", name);
        end
        test_errs = 0;
    endtask

    // plain alu-style instruction that callers extend with csr or exception fields
    task automatic start_instr(input reg_addr_t dest, input word_t result);
        ms_valid     = 1'b1;
        ms_pc        = cur_pc;
        ms_gr_we     = 1'b1;
        ms_dest      = dest;
        ms_result    = result;
        ms_rkd_value = '0;
        ms_csr_re    = 1'b0;
        ms_csr_we    = 1'b0;
        ms_csr_num   = '0;
        ms_csr_wmask = '0;
        ms_ex        = 1'b0;
        ms_ecode     = '0;
        ms_esubcode  = '0;
        ms_badv      = '0;
        ms_ertn      = 1'b0;
        ms_refetch   = 1'b0;
        cur_pc       = cur_pc + 32'd4;
    endtask

    task automatic wait_wb(input bit want_flush, input string what);
        int cycles;
        bit hit;
        cycles = 0;
        hit = 1'b0;
        while (!hit && cycles < 8) begin
            @(negedge clk);
            ms_valid = 1'b0;
            hit = want_flush ? flush : (debug_wb_rf_we != 4'h0);
            cycles++;
        end
        if (!hit) begin
            $display("timeout waiting for %s", what);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic check_commit(input word_t exp_data);
        check_val("debug_wb_pc", debug_wb_pc, ms_pc);
        check_val("debug_wb_rf_we", debug_wb_rf_we, 4'hf);
        check_val("debug_wb_rf_wnum", debug_wb_rf_wnum, ms_dest);
        check_val("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data);
        if (ms_dest != '0) begin
            exp_regs[ms_dest] = exp_data;
            written[ms_dest] = 1'b1;
        end
    endtask

    task automatic check_reg(input reg_addr_t addr, input word_t exp);
        @(negedge clk);
        raddr1 = addr;
        raddr2 = addr;
        #2;
        check_val($sformatf("rdata1 r%0d", addr), rdata1, exp);
        check_val($sformatf("rdata2 r%0d", addr), rdata2, exp);
    endtask

    // csrrd into r30 where the random result must not land
    task automatic check_csr(input csr_num_t num, input word_t exp, input string name);
        @(negedge clk);
        start_instr(5'd30, next_rand());
        ms_csr_re  = 1'b1;
        ms_csr_num = num;
        wait_wb(1'b0, name);
        check_val(name, debug_wb_rf_wdata, exp);
        check_commit(exp);
    endtask

    // csrxchg with the old value going to r29
    task automatic csr_write(input csr_num_t num, input word_t value, input word_t mask,
                             input word_t old_value);
        @(negedge clk);
        start_instr(5'd29, next_rand());
        ms_csr_re    = 1'b1;
        ms_csr_we    = 1'b1;
        ms_csr_num   = num;
        ms_csr_wmask = mask;
        ms_rkd_value = value;
        wait_wb(1'b0, "csr write commit");
        check_commit(old_value);
    endtask

    initial begin
        word_t     r, m, ex_pc, ex_badv;
        esubcode_t ex_sub;
        rng = 32'h770f_ac69;
        cur_pc = 32'h1c00_0000;
        {exp_crmd, exp_prmd, exp_era, exp_save0, written} = '0;
        {test_errs, tests_run, tests_failed} = '0;
        clk = 1'b0;
        reset = 1'b1;
        raddr1 = '0;
        raddr2 = '0;
        start_instr(5'd0, '0);
        ms_valid = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        check_val("flush", flush, 1'b0);
        check_val("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
        check_csr(`CSR_EENTRY, `EENTRY_RESET, "eentry");
        end_test("reset");

        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            r = next_rand();
            start_instr(r[4:0], next_rand());
            wait_wb(1'b0, "commit");
            check_commit(ms_result);
        end
        @(negedge clk);
        start_instr(5'd0, next_rand());
        wait_wb(1'b0, "r0 commit");
        check_commit(ms_result);
        check_reg(5'd0, '0);
        for (int i = 1; i < 32; i++) begin
            if (written[i]) begin
                check_reg(i[4:0], exp_regs[i]);
            end
        end
        end_test("writeback");

        r = next_rand();
        m = next_rand();
        csr_write(`CSR_SAVE0, r, m, exp_save0);
        exp_save0 = (exp_save0 & ~m) | (r & m);
        check_csr(`CSR_SAVE0, exp_save0, "save0");
        // plv bit 0 and ie end up set for the exception test
        r = next_rand() | 32'h5;
        m = next_rand() | 32'h5;
        csr_write(`CSR_CRMD, r, m, exp_crmd);
        exp_crmd = (exp_crmd & ~(m & 32'h7)) | (r & m & 32'h7);
        check_csr(`CSR_CRMD, exp_crmd, "crmd");
        csr_write(`CSR_ESTAT, next_rand(), 32'hffff_ffff, '0);
        check_csr(`CSR_ESTAT, '0, "estat");
        check_csr(14'h3ff, '0, "unknown csr");
        check_csr(`CSR_SAVE0, exp_save0, "save0 again");
        check_reg(5'd30, exp_save0);
        end_test("csr access");

        @(negedge clk);
        start_instr(5'd7, next_rand());
        wait_wb(1'b0, "r7 commit");
        check_commit(ms_result);
        @(negedge clk);
        start_instr(5'd9, next_rand());
        wait_wb(1'b0, "r9 commit");
        check_commit(ms_result);
        @(negedge clk);
        start_instr(5'd7, next_rand());
        r = next_rand();
        ms_ex       = 1'b1;
        ms_ecode    = `ECODE_ALE;
        ms_esubcode = r[8:0];
        ms_badv     = next_rand();
        ex_pc   = ms_pc;
        ex_badv = ms_badv;
        ex_sub  = ms_esubcode;
        wait_wb(1'b1, "exception flush");
        check_val("flush_pc", flush_pc, `EENTRY_RESET);
        check_val("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
        // offered at the flush edge and must be dropped
        start_instr(5'd9, next_rand());
        @(negedge clk);
        ms_valid = 1'b0;
        check_val("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
        check_val("flush", flush, 1'b0);
        check_reg(5'd7, exp_regs[7]);
        check_reg(5'd9, exp_regs[9]);
        exp_prmd = (exp_prmd & ~32'h7) | (exp_crmd & 32'h7);
        exp_crmd = exp_crmd & ~32'h7;
        exp_era  = ex_pc;
        check_csr(`CSR_ERA, ex_pc, "era");
        check_csr(`CSR_BADV, ex_badv, "badv");
        check_csr(`CSR_ESTAT, {1'b0, ex_sub, `ECODE_ALE, 16'h0}, "estat codes");
        check_csr(`CSR_PRMD, exp_prmd, "prmd");
        check_csr(`CSR_CRMD, exp_crmd, "crmd after ex");
        end_test("exception");

        @(negedge clk);
        start_instr(5'd0, '0);
        ms_gr_we = 1'b0;
        ms_ertn  = 1'b1;
        wait_wb(1'b1, "ertn flush");
        check_val("flush_pc", flush_pc, exp_era);
        check_val("debug_wb_rf_we", debug_wb_rf_we, 4'h0);
        exp_crmd = (exp_crmd & ~32'h7) | (exp_prmd & 32'h7);
        check_csr(`CSR_CRMD, exp_crmd, "crmd after ertn");
        end_test("ertn");

        @(negedge clk);
        r = next_rand();
        start_instr(r[4:0] | 5'd1, next_rand());
        ms_refetch = 1'b1;
        wait_wb(1'b1, "refetch flush");
        check_val("flush_pc", flush_pc, ms_pc + 32'd4);
        check_commit(ms_result);
        check_reg(ms_dest, exp_regs[ms_dest]);
        end_test("refetch");

        repeat (2) @(negedge clk);
        $display("tests run %0d, failed %0d, checker failures %0d",
                 tests_run, tests_failed, u_wb_subsys.u_chk.fail_count);
        if (tests_failed == 0 && u_wb_subsys.u_chk.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/wb_pkg.sv
src/csr_if.sv
src/wb_stage.sv
src/csr_file.sv
src/reg_file.sv
src/wb_subsys.sv
dv/wb_subsys_chk.sv
dv/wb_subsys_tb.sv

//--- src/csr_file.sv
`timescale 1ns/100ps

`include "wb_defs.svh"

module csr_file import wb_pkg::*; (
    input logic clk,
    input logic reset,
    csr_if.csr  csr
);

    // writable bits per register
    localparam word_t CRMD_WMASK   = 32'h0000_0007;
    localparam word_t PRMD_WMASK   = 32'h0000_0007;
    localparam word_t EENTRY_WMASK = 32'hffff_ffc0;
    localparam word_t FULL_WMASK   = 32'hffff_ffff;

    word_t crmd;
    word_t prmd;
    word_t estat;
    word_t era;
    word_t badv;
    word_t eentry;
    word_t save0;

    logic  badv_hit;

    function automatic word_t merge(
        input word_t old_value,
        input word_t new_value,
        input word_t wmask,
        input word_t writable
    );
        word_t sel;
        sel   = wmask & writable;
        merge = (old_value & ~sel) | (new_value & sel);
    endfunction

    // only address faults record a bad address
    assign badv_hit = (csr.ecode == `ECODE_ADEF) || (csr.ecode == `ECODE_ALE);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd   <= '0;
            prmd   <= '0;
            estat  <= '0;
            era    <= '0;
            badv   <= '0;
            eentry <= `EENTRY_RESET;
            save0  <= '0;
        end else if (csr.ex) begin
            prmd[`CRMD_PLV]          <= crmd[`CRMD_PLV];
            prmd[`CRMD_IE]           <= crmd[`CRMD_IE];
            crmd[`CRMD_PLV]          <= 2'b00;
            crmd[`CRMD_IE]           <= 1'b0;
            era                      <= csr.pc;
            estat[`ESTAT_ECODE]      <= csr.ecode;
            estat[`ESTAT_ESUBCODE]   <= csr.esubcode;
            if (badv_hit) begin
                badv <= csr.badv;
            end
        end else if (csr.ertn) begin
            // restore privilege and interrupt enable
            crmd[`CRMD_PLV] <= prmd[`CRMD_PLV];
            crmd[`CRMD_IE]  <= prmd[`CRMD_IE];
        end else if (csr.we) begin
            case (csr.num)
                `CSR_CRMD: begin
                    crmd <= merge(crmd, csr.wvalue, csr.wmask, CRMD_WMASK);
                end
                `CSR_PRMD: begin
                    prmd <= merge(prmd, csr.wvalue, csr.wmask, PRMD_WMASK);
                end
                `CSR_ERA: begin
                    era <= merge(era, csr.wvalue, csr.wmask, FULL_WMASK);
                end
                `CSR_BADV: begin
                    badv <= merge(badv, csr.wvalue, csr.wmask, FULL_WMASK);
                end
                `CSR_EENTRY: begin
                    eentry <= merge(eentry, csr.wvalue, csr.wmask, EENTRY_WMASK);
                end
                `CSR_SAVE0: begin
                    save0 <= merge(save0, csr.wvalue, csr.wmask, FULL_WMASK);
                end
                // estat and unknown numbers ignore writes
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        csr.rvalue = '0;
        if (csr.re) begin
            case (csr.num)
                `CSR_CRMD:   csr.rvalue = crmd;
                `CSR_PRMD:   csr.rvalue = prmd;
                `CSR_ESTAT:  csr.rvalue = estat;
                `CSR_ERA:    csr.rvalue = era;
                `CSR_BADV:   csr.rvalue = badv;
                `CSR_EENTRY: csr.rvalue = eentry;
                `CSR_SAVE0:  csr.rvalue = save0;
                default:     csr.rvalue = '0;
            endcase
        end
    end

    // flush targets for the stage
    assign csr.era    = era;
    assign csr.eentry = eentry;

endmodule

//--- src/csr_if.sv
`timescale 1ns/100ps

interface csr_if import wb_pkg::*; ();

    // read and write access
    logic      re;
    logic      we;
    csr_num_t  num;
    word_t     wmask;
    word_t     wvalue;

    // exception entry and return
    logic      ex;
    ecode_t    ecode;
    esubcode_t esubcode;
    word_t     pc;
    word_t     badv;
    logic      ertn;

    // back from the csr unit
    word_t     rvalue;
    word_t     era;
    word_t     eentry;

    modport stage (
        output re, we, num, wmask, wvalue,
        output ex, ecode, esubcode, pc, badv, ertn,
        input  rvalue, era, eentry
    );

    modport csr (
        input  re, we, num, wmask, wvalue,
        input  ex, ecode, esubcode, pc, badv, ertn,
        output rvalue, era, eentry
    );

endinterface

//--- src/reg_file.sv
`timescale 1ns/100ps

`include "wb_defs.svh"

module reg_file import wb_pkg::*; (
    input  logic      clk,

    // write port from writeback
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,

    // asynchronous read ports
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [`NUM_REGS];

    // r0 is hardwired and never stored
    always_ff @(posedge clk) begin
        if (rf_we && (rf_waddr != '0)) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- src/wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// csr numbers
`define CSR_CRMD        14'h0
`define CSR_PRMD        14'h1
`define CSR_ESTAT       14'h5
`define CSR_ERA         14'h6
`define CSR_BADV        14'h7
`define CSR_EENTRY      14'hc
`define CSR_SAVE0       14'h30

// exception codes
`define ECODE_ADEF      6'h08
`define ECODE_ALE       6'h09
`define ECODE_SYS       6'h0b

// crmd fields that prmd shares for pplv and pie
`define CRMD_PLV        1:0
`define CRMD_IE         2

// estat fields
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  30:22

`define EENTRY_RESET    32'h1c00_0000

`define NUM_REGS        32

`endif

//--- src/wb_pkg.sv
package wb_pkg;

    // data, pc and mask words
    typedef logic [31:0] word_t;

    // general register number
    typedef logic [4:0] reg_addr_t;

    // csr number as encoded in csrrd/csrwr/csrxchg
    typedef logic [13:0] csr_num_t;

    // exception code and subcode
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

endpackage

//--- src/wb_stage.sv
`timescale 1ns/100ps

module wb_stage import wb_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // retiring instruction from mem
    input  logic      ms_valid,
    input  word_t     ms_pc,
    input  logic      ms_gr_we,
    input  reg_addr_t ms_dest,
    input  word_t     ms_result,
    input  word_t     ms_rkd_value,
    input  logic      ms_csr_re,
    input  logic      ms_csr_we,
    input  csr_num_t  ms_csr_num,
    input  word_t     ms_csr_wmask,
    input  logic      ms_ex,
    input  ecode_t    ms_ecode,
    input  esubcode_t ms_esubcode,
    input  word_t     ms_badv,
    input  logic      ms_ertn,
    input  logic      ms_refetch,

    csr_if.stage      csr,

    // register file write port
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,

    output logic      flush,
    output word_t     flush_pc,

    output word_t     debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    logic      ws_valid;
    word_t     ws_pc;
    logic      ws_gr_we;
    reg_addr_t ws_dest;
    word_t     ws_result;
    word_t     ws_rkd_value;
    logic      ws_csr_re;
    logic      ws_csr_we;
    csr_num_t  ws_csr_num;
    word_t     ws_csr_wmask;
    logic      ws_ex;
    ecode_t    ws_ecode;
    esubcode_t ws_esubcode;
    word_t     ws_badv;
    logic      ws_ertn;
    logic      ws_refetch;

    logic      ex_fire;
    logic      ertn_fire;
    logic      refetch_fire;

    // always ready, so every offered instruction is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (flush) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid) begin
            ws_pc        <= ms_pc;
            ws_gr_we     <= ms_gr_we;
            ws_dest      <= ms_dest;
            ws_result    <= ms_result;
            ws_rkd_value <= ms_rkd_value;
            ws_csr_re    <= ms_csr_re;
            ws_csr_we    <= ms_csr_we;
            ws_csr_num   <= ms_csr_num;
            ws_csr_wmask <= ms_csr_wmask;
            ws_ex        <= ms_ex;
            ws_ecode     <= ms_ecode;
            ws_esubcode  <= ms_esubcode;
            ws_badv      <= ms_badv;
            ws_ertn      <= ms_ertn;
            ws_refetch   <= ms_refetch;
        end
    end

    // ex beats ertn beats refetch
    assign ex_fire      = ws_valid & ws_ex;
    assign ertn_fire    = ws_valid & ws_ertn & ~ws_ex;
    assign refetch_fire = ws_valid & ws_refetch;

    assign csr.re       = ws_valid & ws_csr_re;
    assign csr.we       = ws_valid & ws_csr_we & ~ws_ex;
    assign csr.num      = ws_csr_num;
    assign csr.wmask    = ws_csr_wmask;
    assign csr.wvalue   = ws_rkd_value;
    assign csr.ex       = ex_fire;
    assign csr.ecode    = ws_ecode;
    assign csr.esubcode = ws_esubcode;
    assign csr.pc       = ws_pc;
    assign csr.badv     = ws_badv;
    assign csr.ertn     = ertn_fire;

    assign flush = ex_fire | ertn_fire | refetch_fire;

    always_comb begin
        if (ws_ex) begin
            flush_pc = csr.eentry;
        end else if (ws_ertn) begin
            flush_pc = csr.era;
        end else begin
            flush_pc = ws_pc + 32'd4;
        end
    end

    // csr reads return the old csr value to rd
    assign rf_we    = ws_valid & ws_gr_we & ~ws_ex;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_csr_re ? csr.rvalue : ws_result;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

//--- src/wb_subsys.sv
`timescale 1ns/100ps

module wb_subsys import wb_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // retiring instruction from mem
    input  logic       ms_valid,
    input  word_t      ms_pc,
    input  logic       ms_gr_we,
    input  reg_addr_t  ms_dest,
    input  word_t      ms_result,
    input  word_t      ms_rkd_value,
    input  logic       ms_csr_re,
    input  logic       ms_csr_we,
    input  csr_num_t   ms_csr_num,
    input  word_t      ms_csr_wmask,
    input  logic       ms_ex,
    input  ecode_t     ms_ecode,
    input  esubcode_t  ms_esubcode,
    input  word_t      ms_badv,
    input  logic       ms_ertn,
    input  logic       ms_refetch,

    output logic       flush,
    output word_t      flush_pc,

    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata,

    // register file read ports
    input  reg_addr_t  raddr1,
    input  reg_addr_t  raddr2,
    output word_t      rdata1,
    output word_t      rdata2
);

    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    csr_if u_csr_if ();

    wb_stage u_wb_stage (
        .clk               (clk),
        .reset             (reset),
        .ms_valid          (ms_valid),
        .ms_pc             (ms_pc),
        .ms_gr_we          (ms_gr_we),
        .ms_dest           (ms_dest),
        .ms_result         (ms_result),
        .ms_rkd_value      (ms_rkd_value),
        .ms_csr_re         (ms_csr_re),
        .ms_csr_we         (ms_csr_we),
        .ms_csr_num        (ms_csr_num),
        .ms_csr_wmask      (ms_csr_wmask),
        .ms_ex             (ms_ex),
        .ms_ecode          (ms_ecode),
        .ms_esubcode       (ms_esubcode),
        .ms_badv           (ms_badv),
        .ms_ertn           (ms_ertn),
        .ms_refetch        (ms_refetch),
        .csr               (u_csr_if.stage),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .flush             (flush),
        .flush_pc          (flush_pc),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file u_csr_file (
        .clk   (clk),
        .reset (reset),
        .csr   (u_csr_if.csr)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .raddr1   (raddr1),
        .raddr2   (raddr2),
        .rdata1   (rdata1),
        .rdata2   (rdata2)
    );

endmodule
